/* rtl/fwdPkg.sv */
/* Source-code type, its special values and the functional-unit count
   shared by the operand write-forward pipeline. */

package fwdPkg;

  // Result bus source code carried with each operand request.
  // 0..8 name units 0..8, 9..14 all name unit 9, 15 names no source.
  typedef logic [3:0] srcCodeT;

  // No forwarding source, so the old register-file value is used.
  localparam srcCodeT srcNone = 4'd15;

  // Unit selected by every code from 9 up to 14.
  localparam int aliasUnit = 9;

  // Functional-unit broadcast buses, current and registered.
  localparam int numUnits = 10;

  // Width of a decoded unit index.
  localparam int unitIdxWidth = $clog2(numUnits);

  typedef logic [unitIdxWidth-1:0] unitIdxT;

  // Fold a source code onto the unit it names.
  // Codes 9 to 15 map to the alias unit, and 15 is filtered by the caller.
  function automatic unitIdxT unitOf(srcCodeT code);
    unitIdxT idx;
    if (code >= srcCodeT'(aliasUnit)) begin
      idx = unitIdxT'(aliasUnit);
    end else begin
      idx = unitIdxT'(code);
    end
    return idx;
  endfunction

  // True when the code names a unit at all.
  function automatic logic isSource(srcCodeT code);
    return code != srcNone;
  endfunction

endpackage

/* rtl/srcCapture.sv */
/* Stage 1 of the forward pipeline, the request register for valid,
   source codes, old data and old flags. */

`timescale 1ns/1ps

module srcCapture import fwdPkg::*; #(
  parameter int dataWidth = 65,
  parameter int flagWidth = 6
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stall,

  // Incoming operand request.
  input  logic                 inValid,
  input  srcCodeT              fastCode,
  input  srcCodeT              lateCode,
  input  logic [dataWidth-1:0] oldData,
  input  logic [flagWidth-1:0] oldFlags,

  // Captured request, read by both selectors and the output latch.
  output logic                 capValid,
  output srcCodeT              capFast,
  output srcCodeT              capLate,
  output logic [dataWidth-1:0] capOldData,
  output logic [flagWidth-1:0] capOldFlags
);

  // Control part of the slot.
  // Codes reset to no source so an empty slot picks the old value.
  always_ff @(posedge clk) begin
    if (rst) begin
      capValid <= 1'b0;
      capFast  <= srcNone;
      capLate  <= srcNone;
    end else if (!stall) begin
      capValid <= inValid;
      capFast  <= fastCode;
      capLate  <= lateCode;
    end
  end

  // Old register-file value and flags.
  // Cleared so that an empty slot forms a zero operand.
  always_ff @(posedge clk) begin
    if (rst) begin
      capOldData  <= '0;
      capOldFlags <= '0;
    end else if (!stall) begin
      capOldData  <= oldData;
      capOldFlags <= oldFlags;
    end
  end

endmodule

/* rtl/bypassSelect.sv */
/* Stage 2 bypass selector, payload-generic, picking the current broadcast,
   the registered broadcast or the old value from a source-code pair. */

`timescale 1ns/1ps

module bypassSelect import fwdPkg::*; #(
  parameter type payloadT = logic [64:0],
  parameter int  numSrc   = numUnits
) (
  input  srcCodeT srcFast,
  input  srcCodeT srcLate,

  // Buses as broadcast this cycle.
  input  payloadT unitNow [numSrc],
  // Buses broadcast one cycle earlier, held in each unit's output register.
  input  payloadT unitReg [numSrc],

  input  payloadT oldValue,
  output payloadT selected
);

  unitIdxT fastIdx;
  unitIdxT lateIdx;
  logic    fastHit;
  logic    lateHit;
  payloadT fastValue;
  payloadT lateValue;

  // Code decode with 9..14 folded onto the alias unit.
  assign fastIdx = unitOf(srcFast);
  assign lateIdx = unitOf(srcLate);

  assign fastHit = isSource(srcFast);
  assign lateHit = isSource(srcLate);

  // Per-source bus pick.
  always_comb begin
    fastValue = unitNow[0];
    lateValue = unitReg[0];
    for (int i = 0; i < numSrc; i++) begin
      if (fastIdx == unitIdxT'(i)) begin
        fastValue = unitNow[i];
      end
      if (lateIdx == unitIdxT'(i)) begin
        lateValue = unitReg[i];
      end
    end
  end

  // Fast over late, late over old.
  always_comb begin
    if (fastHit) begin
      selected = fastValue;
    end else if (lateHit) begin
      selected = lateValue;
    end else begin
      selected = oldValue;
    end
  end

endmodule

/* rtl/operandLatch.sv */
/* Stage 3 output register for the selected operand, its flags
   and the travelling valid bit. */

`timescale 1ns/1ps

module operandLatch #(
  parameter int dataWidth = 65,
  parameter int flagWidth = 6
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stall,

  // From the capture stage and the two selectors.
  input  logic                 capValid,
  input  logic [dataWidth-1:0] selData,
  input  logic [flagWidth-1:0] selFlags,

  // Finished operand toward the reservation station entry.
  output logic                 outValid,
  output logic [dataWidth-1:0] operand,
  output logic [flagWidth-1:0] operandFlags
);

  // Valid bit of the item in the last slot.
  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
    end else if (!stall) begin
      outValid <= capValid;
    end
  end

  // Operand and flags hold while stalled.
  // Formed even for invalid slots, as the selection rule still applies.
  always_ff @(posedge clk) begin
    if (rst) begin
      operand      <= '0;
      operandFlags <= '0;
    end else if (!stall) begin
      operand      <= selData;
      operandFlags <= selFlags;
    end
  end

endmodule

/* rtl/rsForwardTop.sv */
/* Operand write-forward pipeline top, request capture,
   data and flag bypass selectors and the output register. */

`timescale 1ns/1ps

module rsForwardTop import fwdPkg::*; #(
  parameter int dataWidth = 65,
  parameter int flagWidth = 6
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stall,

  // Operand request.
  input  logic                 inValid,
  input  srcCodeT              fastCode,
  input  srcCodeT              lateCode,
  input  logic [dataWidth-1:0] oldData,
  input  logic [flagWidth-1:0] oldFlags,

  // Functional-unit result buses, current and registered.
  input  logic [dataWidth-1:0] unitData     [numUnits],
  input  logic [dataWidth-1:0] unitDataReg  [numUnits],
  input  logic [flagWidth-1:0] unitFlags    [numUnits],
  input  logic [flagWidth-1:0] unitFlagsReg [numUnits],

  // Forwarded operand.
  output logic                 outValid,
  output logic [dataWidth-1:0] operand,
  output logic [flagWidth-1:0] operandFlags
);

  logic                 capValid;
  srcCodeT              capFast;
  srcCodeT              capLate;
  logic [dataWidth-1:0] capOldData;
  logic [flagWidth-1:0] capOldFlags;

  logic [dataWidth-1:0] selData;
  logic [flagWidth-1:0] selFlags;

  // Stage 1.
  srcCapture #(
    .dataWidth (dataWidth),
    .flagWidth (flagWidth)
  ) capture (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .inValid     (inValid),
    .fastCode    (fastCode),
    .lateCode    (lateCode),
    .oldData     (oldData),
    .oldFlags    (oldFlags),
    .capValid    (capValid),
    .capFast     (capFast),
    .capLate     (capLate),
    .capOldData  (capOldData),
    .capOldFlags (capOldFlags)
  );

  // Stage 2 with one selector per payload on the captured codes.
  bypassSelect #(
    .payloadT (logic [dataWidth-1:0]),
    .numSrc   (numUnits)
  ) dataSel (
    .srcFast  (capFast),
    .srcLate  (capLate),
    .unitNow  (unitData),
    .unitReg  (unitDataReg),
    .oldValue (capOldData),
    .selected (selData)
  );

  bypassSelect #(
    .payloadT (logic [flagWidth-1:0]),
    .numSrc   (numUnits)
  ) flagSel (
    .srcFast  (capFast),
    .srcLate  (capLate),
    .unitNow  (unitFlags),
    .unitReg  (unitFlagsReg),
    .oldValue (capOldFlags),
    .selected (selFlags)
  );

  // Stage 3.
  operandLatch #(
    .dataWidth (dataWidth),
    .flagWidth (flagWidth)
  ) latch (
    .clk          (clk),
    .rst          (rst),
    .stall        (stall),
    .capValid     (capValid),
    .selData      (selData),
    .selFlags     (selFlags),
    .outValid     (outValid),
    .operand      (operand),
    .operandFlags (operandFlags)
  );

endmodule

/* bench/rsForwardTb.sv */
/* Trace-driven testbench for the operand write-forward pipeline,
   with unit-bus patterns and per-cycle output checks. */

`timescale 1ns/1ps

module rsForwardTb import fwdPkg::*; ();

  localparam int dataWidth      = 65;
  localparam int flagWidth      = 6;
  localparam int clkPeriod      = 40;
  localparam int resetCycles    = 8;
  localparam int drainCycles    = 20;
  localparam int maxCycles      = 64;
  localparam int fieldsPerCycle = 10;
  localparam int wordWidth      = 68;
  localparam int traceDepth     = maxCycles * fieldsPerCycle;

  // Trace columns in file order.
  localparam int colStall      = 0;
  localparam int colValid      = 1;
  localparam int colFast       = 2;
  localparam int colLate       = 3;
  localparam int colOldData    = 4;
  localparam int colOldFlags   = 5;
  localparam int colTag        = 6;
  localparam int colExpValid   = 7;
  localparam int colExpOperand = 8;
  localparam int colExpFlags   = 9;

  // Marks words that the trace did not fill.
  localparam logic [wordWidth-1:0] emptyWord = '1;

  logic                 clk;
  logic                 rst;
  logic                 stall;
  logic                 inValid;
  srcCodeT              fastCode;
  srcCodeT              lateCode;
  logic [dataWidth-1:0] oldData;
  logic [flagWidth-1:0] oldFlags;
  logic [dataWidth-1:0] unitData     [numUnits];
  logic [dataWidth-1:0] unitDataReg  [numUnits];
  logic [flagWidth-1:0] unitFlags    [numUnits];
  logic [flagWidth-1:0] unitFlagsReg [numUnits];

  logic                 outValid;
  logic [dataWidth-1:0] operand;
  logic [flagWidth-1:0] operandFlags;

  logic [wordWidth-1:0] traceMem [traceDepth];
  int                   traceLen;
  int                   cycleCount;
  int                   cycleLimit;

  rsForwardTop #(
    .dataWidth (dataWidth),
    .flagWidth (flagWidth)
  ) dut (
    .clk          (clk),
    .rst          (rst),
    .stall        (stall),
    .inValid      (inValid),
    .fastCode     (fastCode),
    .lateCode     (lateCode),
    .oldData      (oldData),
    .oldFlags     (oldFlags),
    .unitData     (unitData),
    .unitDataReg  (unitDataReg),
    .unitFlags    (unitFlags),
    .unitFlagsReg (unitFlagsReg),
    .outValid     (outValid),
    .operand      (operand),
    .operandFlags (operandFlags)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Watchdog on the total cycle count.
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      stopWithFailure();
    end
  end

  // Bus contents built from the trace tag and the unit index.
  // Current buses carry an A marker nibble, registered buses a B.
  function automatic logic [dataWidth-1:0] liveData(input logic [7:0] tag, input int unit);
    return {1'b1, tag, 4'hA, 4'(unit), 48'h0123_4567_89AB};
  endfunction

  function automatic logic [dataWidth-1:0] heldData(input logic [7:0] tag, input int unit);
    return {1'b0, tag, 4'hB, 4'(unit), 48'h0123_4567_89AB};
  endfunction

  function automatic logic [flagWidth-1:0] liveFlags(input logic [7:0] tag, input int unit);
    return {1'b1, tag[0], 4'(unit)};
  endfunction

  function automatic logic [flagWidth-1:0] heldFlags(input logic [7:0] tag, input int unit);
    return {1'b0, tag[0], 4'(unit)};
  endfunction

  task automatic stopWithFailure();
    $display("Verification failed");
    $fatal(1, "Run stopped at the first failure.");
  endtask

  task automatic checkValue(input string name, input logic [wordWidth-1:0] got,
                            input logic [wordWidth-1:0] expected);
    if (got !== expected) begin
      $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, expected);
      stopWithFailure();
    end
  endtask

  task automatic loadTrace();
    for (int i = 0; i < traceDepth; i++) begin
      traceMem[i] = emptyWord;
    end
    $readmemh("bench/fwdTrace.txt", traceMem);
    traceLen = 0;
    while (traceLen < maxCycles && traceMem[traceLen * fieldsPerCycle] !== emptyWord) begin
      traceLen++;
    end
    if (traceLen == 0) begin
      $display("The trace file bench/fwdTrace.txt is missing or holds no cycles");
      stopWithFailure();
    end
    for (int row = 0; row < traceLen; row++) begin
      if (traceMem[row * fieldsPerCycle + colExpFlags] === emptyWord) begin
        $display("Trace cycle %0d has fewer than %0d fields", row, fieldsPerCycle);
        stopWithFailure();
      end
    end
  endtask

  // Drives one trace cycle right after the rising edge.
  task automatic applyCycle(input int row);
    int         base;
    logic [7:0] tag;
    base = row * fieldsPerCycle;
    tag  = traceMem[base + colTag][7:0];
    stall    <= traceMem[base + colStall][0];
    inValid  <= traceMem[base + colValid][0];
    fastCode <= traceMem[base + colFast][3:0];
    lateCode <= traceMem[base + colLate][3:0];
    oldData  <= traceMem[base + colOldData][dataWidth-1:0];
    oldFlags <= traceMem[base + colOldFlags][flagWidth-1:0];
    for (int u = 0; u < numUnits; u++) begin
      unitData[u]     <= liveData(tag, u);
      unitDataReg[u]  <= heldData(tag, u);
      unitFlags[u]    <= liveFlags(tag, u);
      unitFlagsReg[u] <= heldFlags(tag, u);
    end
  endtask

  task automatic checkCycle(input int row);
    int base;
    base = row * fieldsPerCycle;
    checkValue("outValid", outValid, traceMem[base + colExpValid]);
    checkValue("operand", operand, traceMem[base + colExpOperand]);
    checkValue("operandFlags", operandFlags, traceMem[base + colExpFlags]);
  endtask

  initial begin
    rst        = 1'b1;
    stall      = 1'b0;
    inValid    = 1'b0;
    fastCode   = srcNone;
    lateCode   = srcNone;
    oldData    = '0;
    oldFlags   = '0;
    cycleCount = 0;
    for (int u = 0; u < numUnits; u++) begin
      unitData[u]     = liveData(8'h00, u);
      unitDataReg[u]  = heldData(8'h00, u);
      unitFlags[u]    = liveFlags(8'h00, u);
      unitFlagsReg[u] = heldFlags(8'h00, u);
    end

    loadTrace();
    cycleLimit = resetCycles + traceLen + drainCycles;

    repeat (resetCycles) @(posedge clk);
    rst <= 1'b0;

    // Outputs are checked at the falling edge, after the drive of the same cycle.
    for (int row = 0; row < traceLen; row++) begin
      @(posedge clk);
      applyCycle(row);
      @(negedge clk);
      checkCycle(row);
    end

    $display("Verification passed");
    $finish;
  end

endmodule

/* bench/fwdTrace.txt */
// One cycle per line, all fields hex:
// stall inValid fastCode lateCode oldData oldFlags busTag expValid expOperand expFlags
// Idle after reset, then fast codes 0 to 14
0 0 F F 00000000000000000 00 00 0 00000000000000000 00
0 0 F F 00000000000000000 00 01 0 00000000000000000 00
0 1 0 F 1CAFE000000000002 02 02 0 00000000000000000 00
0 1 1 F 1CAFE000000000003 03 03 0 00000000000000000 00
0 1 2 F 1CAFE000000000004 04 04 1 103A00123456789AB 30
0 1 3 F 1CAFE000000000005 05 05 1 104A10123456789AB 21
0 1 4 F 1CAFE000000000006 06 06 1 105A20123456789AB 32
0 1 5 F 1CAFE000000000007 07 07 1 106A30123456789AB 23
0 1 6 F 1CAFE000000000008 08 08 1 107A40123456789AB 34
0 1 7 F 1CAFE000000000009 09 09 1 108A50123456789AB 25
0 1 8 F 1CAFE00000000000A 0A 0A 1 109A60123456789AB 36
0 1 9 F 1CAFE00000000000B 0B 0B 1 10AA70123456789AB 27
0 1 A F 1CAFE00000000000C 0C 0C 1 10BA80123456789AB 38
0 1 B F 1CAFE00000000000D 0D 0D 1 10CA90123456789AB 29
0 1 C F 1CAFE00000000000E 0E 0E 1 10DA90123456789AB 39
0 1 D F 1CAFE00000000000F 0F 0F 1 10EA90123456789AB 29
0 1 E F 1CAFE000000000010 10 10 1 10FA90123456789AB 39
// Late codes 0 to 14 with no fast source
0 1 F 0 1CAFE000000000011 11 11 1 110A90123456789AB 29
0 1 F 1 1CAFE000000000012 12 12 1 111A90123456789AB 39
0 1 F 2 1CAFE000000000013 13 13 1 012B00123456789AB 00
0 1 F 3 1CAFE000000000014 14 14 1 013B10123456789AB 11
0 1 F 4 1CAFE000000000015 15 15 1 014B20123456789AB 02
0 1 F 5 1CAFE000000000016 16 16 1 015B30123456789AB 13
0 1 F 6 1CAFE000000000017 17 17 1 016B40123456789AB 04
0 1 F 7 1CAFE000000000018 18 18 1 017B50123456789AB 15
0 1 F 8 1CAFE000000000019 19 19 1 018B60123456789AB 06
0 1 F 9 1CAFE00000000001A 1A 1A 1 019B70123456789AB 17
0 1 F A 1CAFE00000000001B 1B 1B 1 01AB80123456789AB 08
0 1 F B 1CAFE00000000001C 1C 1C 1 01BB90123456789AB 19
0 1 F C 1CAFE00000000001D 1D 1D 1 01CB90123456789AB 09
0 1 F D 1CAFE00000000001E 1E 1E 1 01DB90123456789AB 19
0 1 F E 1CAFE00000000001F 1F 1F 1 01EB90123456789AB 09
// Fast over late, then the old value, then invalid slots
0 1 3 7 1CAFE000000000020 20 20 1 01FB90123456789AB 19
0 1 E 0 1CAFE000000000021 21 21 1 020B90123456789AB 09
0 1 F F 1CAFE000000000022 22 22 1 121A30123456789AB 33
0 1 F F 1CAFE000000000023 23 23 1 122A90123456789AB 29
0 0 2 F 1CAFE000000000024 24 24 1 1CAFE000000000022 22
0 0 F F 1CAFE000000000025 25 25 1 1CAFE000000000023 23
// Three-cycle stall with a held request, then back-to-back requests
0 1 4 F 1CAFE000000000026 26 26 0 125A20123456789AB 32
0 1 F 6 1CAFE000000000027 27 27 0 1CAFE000000000025 25
1 1 1 3 1CAFE000000000028 28 28 1 127A40123456789AB 34
1 1 1 3 1CAFE000000000028 28 29 1 127A40123456789AB 34
1 1 1 3 1CAFE000000000028 28 2A 1 127A40123456789AB 34
0 1 1 3 1CAFE000000000028 28 2B 1 127A40123456789AB 34
0 1 8 2 1CAFE00000000002C 2C 2C 1 02BB60123456789AB 16
0 1 F 9 1CAFE00000000002D 2D 2D 1 12CA10123456789AB 21
0 1 F F 1CAFE00000000002E 2E 2E 1 12DA80123456789AB 38
// Single-cycle stall, then a two-cycle stall while draining
1 1 6 F 1CAFE00000000002F 2F 2F 1 02EB90123456789AB 09
0 1 6 F 1CAFE00000000002F 2F 30 1 02EB90123456789AB 09
0 1 0 1 1CAFE000000000031 31 31 1 1CAFE00000000002E 2E
0 1 9 4 1CAFE000000000032 32 32 1 131A60123456789AB 36
1 0 F F 00000000000000000 00 33 1 132A00123456789AB 20
1 0 F F 00000000000000000 00 34 1 132A00123456789AB 20
0 0 F F 00000000000000000 00 35 1 132A00123456789AB 20
0 0 F F 00000000000000000 00 36 1 135A90123456789AB 39
0 0 F F 00000000000000000 00 37 0 00000000000000000 00

/* list.f */
rtl/fwdPkg.sv
rtl/srcCapture.sv
rtl/bypassSelect.sv
rtl/operandLatch.sv
rtl/rsForwardTop.sv
bench/rsForwardTb.sv
